// File: hw/x25519_config.svh
`ifndef X25519_CONFIG_SVH
`define X25519_CONFIG_SVH

// unreduced element width, 255 field bits plus 9 bits of headroom
`define X25519_ELEM_W 264

// low limb width, the high limb takes the rest of the element
`define X25519_LIMB_W 128

// bit position of 2^255, where p and the weak fold split the element
`define X25519_FIELD_BITS 255

// weak reduction passes run for ADD_RED and SUB_RED
`define X25519_RED_PASSES 2

// pass counter width, must hold X25519_RED_PASSES
`define X25519_PASS_CNT_W 2

`endif

// File: hw/x25519_field_pkg.sv
`default_nettype none

`include "x25519_config.svh"

package x25519_field_pkg;

	// one field element in unreduced form (9 words of 32 bits)
	typedef logic [`X25519_ELEM_W-1:0] felem_t;

	// command opcodes
	// bit 1 selects the weak reduction tail, bit 0 selects subtract
	typedef enum logic [1:0] {
		OP_ADD     = 2'b00, // a+b mod 2^264
		OP_SUB     = 2'b01, // a-b+p mod 2^264
		OP_ADD_RED = 2'b10, // add, then weak reduce
		OP_SUB_RED = 2'b11  // sub, then weak reduce
	} opcode_t;

endpackage

`default_nettype wire

// File: hw/x25519_ctrl_pkg.sv
`default_nettype none

package x25519_ctrl_pkg;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'b00, // waiting for cmd_valid
		ST_ARITH  = 2'b01, // add or sub in flight
		ST_REDUCE = 2'b10, // weak reduction loop running
		ST_DONE   = 2'b11  // result_valid cycle
	} seq_state_t;

	// incoming command, 2 + 264 + 264 bits
	typedef struct packed {
		x25519_field_pkg::opcode_t op; // what to compute
		x25519_field_pkg::felem_t  a;  // first operand
		x25519_field_pkg::felem_t  b;  // second operand
	} field_cmd_t;

	// outgoing result, 2 + 264 bits
	// op is echoed back so the host can pair results with commands
	typedef struct packed {
		x25519_field_pkg::opcode_t op;    // opcode of the command
		x25519_field_pkg::felem_t  value; // computed element
	} field_result_t;

endpackage

`default_nettype wire

// File: hw/x25519_add.sv
`timescale 1ns/1ns
`default_nettype none

`include "x25519_config.svh"

module x25519_add (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      en,
	input  wire x25519_field_pkg::felem_t a,
	input  wire x25519_field_pkg::felem_t b,
	output logic                     out_valid,
	output x25519_field_pkg::felem_t out
);

	localparam int LIMB_W = `X25519_LIMB_W;
	localparam int HIGH_W = `X25519_ELEM_W - `X25519_LIMB_W;

	logic [1:0]        valid_sr;  // same two stage latency as the subtractor
	logic [LIMB_W:0]   sum_low;   // low limb plus its carry out
	logic [HIGH_W-1:0] sum_high;  // high limb without the low carry

	assign out_valid = valid_sr[1];

	always_ff @(posedge clk) begin
		if (reset)
			valid_sr <= 2'b00;
		else
			valid_sr <= {valid_sr[0], en};
	end

	always_ff @(posedge clk) begin
		if (en) begin
			sum_low  <= {1'b0, a[LIMB_W-1:0]} + {1'b0, b[LIMB_W-1:0]};
			sum_high <= a[`X25519_ELEM_W-1:LIMB_W] + b[`X25519_ELEM_W-1:LIMB_W];
		end
		if (valid_sr[0])
			out <= {sum_high + {{(HIGH_W-1){1'b0}}, sum_low[LIMB_W]},
				sum_low[LIMB_W-1:0]}; // wraps mod 2^264
	end

endmodule

`default_nettype wire

// File: hw/x25519_sub.sv
`timescale 1ns/1ns
`default_nettype none

`include "x25519_config.svh"

module x25519_sub (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      en,
	input  wire x25519_field_pkg::felem_t a,
	input  wire x25519_field_pkg::felem_t b,
	output logic                     out_valid,
	output x25519_field_pkg::felem_t out
);

	localparam int LIMB_W = `X25519_LIMB_W;
	localparam int HIGH_W = `X25519_ELEM_W - `X25519_LIMB_W;  // 136 bits
	localparam int P_HIGH_ONES = `X25519_FIELD_BITS - `X25519_LIMB_W; // ones of p in high limb

	localparam logic [LIMB_W-1:0] P_LOW = ~LIMB_W'(18); // 2^128 - 19
	localparam logic [HIGH_W-1:0] P_HIGH = {{(HIGH_W-P_HIGH_ONES){1'b0}}, {P_HIGH_ONES{1'b1}}};

	logic [1:0]        valid_sr;  // en delayed by one and two cycles
	logic [LIMB_W+1:0] sum_low;   // two carry bits on top, may be 0..2
	logic [HIGH_W-1:0] sum_high;  // wraps mod 2^136

	assign out_valid = valid_sr[1];

	always_ff @(posedge clk) begin
		if (reset)
			valid_sr <= 2'b00;
		else
			valid_sr <= {valid_sr[0], en};
	end

	// a-b+p computed as a + ~b + 1 + p, so nothing in the low limb can go negative
	always_ff @(posedge clk) begin
		if (en) begin
			sum_low <= {2'b00, a[LIMB_W-1:0]} + {2'b00, ~b[LIMB_W-1:0]} +
				{2'b00, P_LOW} + (LIMB_W+2)'(1); // the +1 completes the negation of b
			sum_high <= a[`X25519_ELEM_W-1:LIMB_W] + ~b[`X25519_ELEM_W-1:LIMB_W] + P_HIGH;
		end
		if (valid_sr[0])
			out <= {sum_high + {{(HIGH_W-2){1'b0}}, sum_low[LIMB_W+1:LIMB_W]},
				sum_low[LIMB_W-1:0]}; // carry merge, overflow past 2^264 is dropped
	end

endmodule

`default_nettype wire

// File: hw/x25519_reduce.sv
`timescale 1ns/1ns
`default_nettype none

`include "x25519_config.svh"

module x25519_reduce (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      en,
	input  wire x25519_field_pkg::felem_t x,
	output logic                     out_valid,
	output x25519_field_pkg::felem_t out
);

	localparam int FIELD_BITS = `X25519_FIELD_BITS;
	localparam int FOLD_W = `X25519_ELEM_W - `X25519_FIELD_BITS; // 9 bits above 2^255
	localparam int PROD_W = FOLD_W + 5;                           // 19 < 2^5
	localparam int PAD_W = `X25519_ELEM_W - PROD_W;

	logic [FOLD_W-1:0] fold;      // x div 2^255
	logic [PROD_W-1:0] fold_x19;  // 19 * fold

	assign fold = x[`X25519_ELEM_W-1:FIELD_BITS];

	// 19 = 16 + 2 + 1, plain adders keep this out of the multiplier blocks
	assign fold_x19 = {1'b0, fold, 4'b0000} +
		{4'b0000, fold, 1'b0} +
		{5'b00000, fold};

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= en;
	end

	// 2^255 = 19 mod p, so the folded value stays congruent to x
	// result is below 2^255 + 19*511, which still fits easily
	always_ff @(posedge clk) begin
		if (en)
			out <= {{FOLD_W{1'b0}}, x[FIELD_BITS-1:0]} + {{PAD_W{1'b0}}, fold_x19};
	end

endmodule

`default_nettype wire

// File: hw/x25519_pass_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "x25519_config.svh"

module x25519_pass_counter (
	input  wire  clk,
	input  wire  reset,
	input  wire  load,
	input  wire  dec,
	output logic last_pass
);

	localparam int CNT_W = `X25519_PASS_CNT_W;
	localparam logic [CNT_W-1:0] PASSES = `X25519_RED_PASSES;

	logic [CNT_W-1:0] count;  // passes still to run, including the one in flight

	// high while the pass now in the reducer is the final one
	assign last_pass = (count == CNT_W'(1));

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= PASSES;             // load wins over dec
		end else if (dec && (count != '0)) begin
			count <= count - CNT_W'(1);  // never wraps below zero
		end
	end

endmodule

`default_nettype wire

// File: hw/x25519_op_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module x25519_op_sequencer (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              cmd_valid,
	input  wire x25519_ctrl_pkg::field_cmd_t cmd,
	output logic                             busy,
	output logic                             cmd_dropped,
	output logic                             add_en,
	output logic                             sub_en,
	output x25519_field_pkg::felem_t         operand_a,
	output x25519_field_pkg::felem_t         operand_b,
	input  wire                              arith_valid,
	input  wire x25519_field_pkg::felem_t    arith_out,
	output logic                             red_en,
	output x25519_field_pkg::felem_t         red_in,
	input  wire                              red_valid,
	input  wire x25519_field_pkg::felem_t    red_out,
	output logic                             cnt_load,
	output logic                             cnt_dec,
	input  wire                              last_pass,
	output logic                             result_valid,
	output x25519_ctrl_pkg::field_result_t   result
);

	x25519_ctrl_pkg::seq_state_t state;
	x25519_ctrl_pkg::field_cmd_t cmd_q;  // command in flight
	logic reducing;                      // _RED opcode latched
	logic arith_done;                    // arithmetic result arrives this cycle
	logic loop_done;                     // final reduce pass arrives this cycle

	assign reducing = (cmd_q.op == x25519_field_pkg::OP_ADD_RED) ||
		(cmd_q.op == x25519_field_pkg::OP_SUB_RED);
	assign arith_done = (state == x25519_ctrl_pkg::ST_ARITH) && arith_valid;
	assign loop_done = (state == x25519_ctrl_pkg::ST_REDUCE) && red_valid && last_pass;

	assign busy = (state != x25519_ctrl_pkg::ST_IDLE);
	assign operand_a = cmd_q.a;
	assign operand_b = cmd_q.b;

	// reduce loop runs back to back, one pass per cycle
	assign red_en = (arith_done && reducing) ||
		((state == x25519_ctrl_pkg::ST_REDUCE) && red_valid && !last_pass);
	assign red_in = (state == x25519_ctrl_pkg::ST_ARITH) ? arith_out : red_out;
	assign cnt_load = arith_done && reducing;  // loop starts
	assign cnt_dec = (state == x25519_ctrl_pkg::ST_REDUCE) && red_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= x25519_ctrl_pkg::ST_IDLE;
			add_en       <= 1'b0;
			sub_en       <= 1'b0;
			result_valid <= 1'b0;
			cmd_dropped  <= 1'b0;
		end else begin
			add_en       <= 1'b0;  // strobes default low
			sub_en       <= 1'b0;
			result_valid <= 1'b0;
			cmd_dropped  <= cmd_valid && busy;  // no queue, flag and forget
			case (state)
				x25519_ctrl_pkg::ST_IDLE: begin
					if (cmd_valid) begin
						state  <= x25519_ctrl_pkg::ST_ARITH;
						add_en <= (cmd.op == x25519_field_pkg::OP_ADD) ||
							(cmd.op == x25519_field_pkg::OP_ADD_RED);
						sub_en <= (cmd.op == x25519_field_pkg::OP_SUB) ||
							(cmd.op == x25519_field_pkg::OP_SUB_RED);
					end
				end
				x25519_ctrl_pkg::ST_ARITH: begin
					if (arith_valid) begin
						if (reducing) begin
							state <= x25519_ctrl_pkg::ST_REDUCE;
						end else begin
							state        <= x25519_ctrl_pkg::ST_DONE;
							result_valid <= 1'b1;
						end
					end
				end
				x25519_ctrl_pkg::ST_REDUCE: begin
					if (loop_done) begin
						state        <= x25519_ctrl_pkg::ST_DONE;
						result_valid <= 1'b1;
					end
				end
				default: state <= x25519_ctrl_pkg::ST_IDLE;  // ST_DONE, still busy this cycle
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if ((state == x25519_ctrl_pkg::ST_IDLE) && cmd_valid)
			cmd_q <= cmd;
		if (arith_done && !reducing) begin
			result.op    <= cmd_q.op;
			result.value <= arith_out;
		end else if (loop_done) begin
			result.op    <= cmd_q.op;
			result.value <= red_out;
		end
	end

endmodule

`default_nettype wire

// File: hw/x25519_field_unit.sv
`timescale 1ns/1ns
`default_nettype none

module x25519_field_unit (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              cmd_valid,
	input  wire x25519_ctrl_pkg::field_cmd_t cmd,
	output logic                             busy,
	output logic                             cmd_dropped,
	output logic                             result_valid,
	output x25519_ctrl_pkg::field_result_t   result
);

	logic add_en;
	logic sub_en;
	logic add_valid;
	logic sub_valid;
	logic arith_valid;
	logic red_en;
	logic red_valid;
	logic cnt_load;
	logic cnt_dec;
	logic last_pass;
	x25519_field_pkg::felem_t operand_a;
	x25519_field_pkg::felem_t operand_b;
	x25519_field_pkg::felem_t add_out;
	x25519_field_pkg::felem_t sub_out;
	x25519_field_pkg::felem_t arith_out;
	x25519_field_pkg::felem_t red_in;
	x25519_field_pkg::felem_t red_out;

	// only one arithmetic block runs per command
	assign arith_valid = add_valid | sub_valid;
	assign arith_out = add_valid ? add_out : sub_out;  // the valid one wins

	x25519_op_sequencer x25519_op_sequencer_i (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.busy         (busy),
		.cmd_dropped  (cmd_dropped),
		.add_en       (add_en),
		.sub_en       (sub_en),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.arith_valid  (arith_valid),
		.arith_out    (arith_out),
		.red_en       (red_en),
		.red_in       (red_in),
		.red_valid    (red_valid),
		.red_out      (red_out),
		.cnt_load     (cnt_load),
		.cnt_dec      (cnt_dec),
		.last_pass    (last_pass),
		.result_valid (result_valid),
		.result       (result)
	);

	x25519_pass_counter x25519_pass_counter_i (
		.clk       (clk),
		.reset     (reset),
		.load      (cnt_load),
		.dec       (cnt_dec),
		.last_pass (last_pass)
	);

	x25519_add x25519_add_i (
		.clk       (clk),
		.reset     (reset),
		.en        (add_en),
		.a         (operand_a),
		.b         (operand_b),
		.out_valid (add_valid),
		.out       (add_out)
	);

	x25519_sub x25519_sub_i (
		.clk       (clk),
		.reset     (reset),
		.en        (sub_en),
		.a         (operand_a),
		.b         (operand_b),
		.out_valid (sub_valid),
		.out       (sub_out)
	);

	x25519_reduce x25519_reduce_i (
		.clk       (clk),
		.reset     (reset),
		.en        (red_en),
		.x         (red_in),
		.out_valid (red_valid),
		.out       (red_out)
	);

endmodule

`default_nettype wire

// File: testbench/x25519_field_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "x25519_config.svh"

module x25519_field_unit_tb;

	localparam int MAX_VECTORS = 64;
	localparam int PLAIN_LATENCY = 4;                          // cmd_valid edge to result_valid
	localparam int RED_LATENCY = 4 + `X25519_RED_PASSES;       // plus one cycle per pass
	localparam int MAX_WAIT = RED_LATENCY + 4;
	localparam int VECTOR_CYCLES = 6 + 3 + 4;                  // latency, longest gap, slack
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int DROP_CYCLE = 3;                             // one cycle after the second strobe

	logic clk;
	logic reset;
	logic cmd_valid;
	x25519_ctrl_pkg::field_cmd_t cmd;
	logic busy;
	logic cmd_dropped;
	logic result_valid;
	x25519_ctrl_pkg::field_result_t result;

	logic [`X25519_ELEM_W-1:0] vec_mem [0:4*MAX_VECTORS-1];  // op, a, b, expected per vector
	int num_vectors;
	bit vectors_loaded;
	int errors;
	int checks;
	integer seed;

	x25519_field_unit x25519_field_unit_i (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.busy         (busy),
		.cmd_dropped  (cmd_dropped),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [`X25519_ELEM_W-1:0] expected,
			input logic [`X25519_ELEM_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// one command, optionally with a second strobe while the first is in flight
	task automatic run_vector(input int idx, input bit with_drop);
		x25519_field_pkg::opcode_t op;
		logic [`X25519_ELEM_W-1:0] a_val;
		logic [`X25519_ELEM_W-1:0] b_val;
		logic [`X25519_ELEM_W-1:0] exp_val;
		int exp_latency;
		int latency;
		int drop_at;
		bit seen;
		string tag;
		op = x25519_field_pkg::opcode_t'(vec_mem[4*idx][1:0]);
		a_val = vec_mem[4*idx+1];
		b_val = vec_mem[4*idx+2];
		exp_val = vec_mem[4*idx+3];
		exp_latency = (op == x25519_field_pkg::OP_ADD_RED || op == x25519_field_pkg::OP_SUB_RED) ?
			RED_LATENCY : PLAIN_LATENCY;
		tag = $sformatf("vector %0d", idx);
		latency = 0;
		drop_at = 0;
		seen = 1'b0;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd.op    <= op;
		cmd.a     <= a_val;
		cmd.b     <= b_val;
		while (!seen && latency < MAX_WAIT) begin
			@(negedge clk);  // outputs settled here
			check_value({tag, " busy"}, latency > 0, busy);  // low until the command is taken
			if (cmd_dropped) begin
				if (with_drop && drop_at == 0) begin
					drop_at = latency;
				end else begin
					errors++;
					$display("unexpected cmd_dropped pulse while running %s", tag);
				end
			end
			if (result_valid) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
				latency++;  // edges since cmd_valid went high
				cmd_valid <= with_drop && latency == 2;  // collides with the busy unit
				if (with_drop && latency == 2) begin
					cmd.op <= x25519_field_pkg::opcode_t'(op ^ 2'b01);  // must not leak in
					cmd.a  <= b_val;
					cmd.b  <= a_val;
				end
			end
		end
		if (!seen) begin
			errors++;
			$display("no result_valid for %s within %0d cycles", tag, MAX_WAIT);
		end else begin
			check_value({tag, " latency"}, exp_latency, latency);
			check_value({tag, " op"}, op, result.op);
			check_value({tag, " value"}, exp_val, result.value);
		end
		if (with_drop && drop_at == 0) begin
			errors++;
			$display("no cmd_dropped pulse for the second command of %s", tag);
		end else if (with_drop) begin
			check_value({tag, " drop cycle"}, DROP_CYCLE, drop_at);
		end
		repeat (with_drop ? 3 : 1) begin  // unit must fall idle, no second result
			@(posedge clk);
			cmd_valid <= 1'b0;
			@(negedge clk);
			check_value({tag, " busy after result"}, 1'b0, busy);
			check_value({tag, " extra result_valid"}, 1'b0, result_valid);
			check_value({tag, " extra cmd_dropped"}, 1'b0, cmd_dropped);
		end
	endtask

	initial begin
		int gap;
		seed = 98584;
		errors = 0;
		checks = 0;
		cmd_valid = 1'b0;
		cmd = '0;
		reset = 1'b1;
		$readmemh("testbench/x25519_field_vectors.mem", vec_mem);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && !$isunknown(vec_mem[4*num_vectors]))
			num_vectors++;
		vectors_loaded = 1'b1;
		if (num_vectors == 0) begin
			errors++;
			$display("no vectors were loaded from testbench/x25519_field_vectors.mem");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset busy", 1'b0, busy);
		check_value("reset result_valid", 1'b0, result_valid);
		check_value("reset cmd_dropped", 1'b0, cmd_dropped);
		for (int idx = 0; idx < num_vectors; idx++) begin
			gap = $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
			repeat (gap) @(posedge clk);
			run_vector(idx, (idx % 4) == 2);
		end
		$display("%0d vectors, %0d checks, %0d errors", num_vectors, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog, budget grows with the vector count
	initial begin
		int timeout_ns;
		wait (vectors_loaded);
		timeout_ns = (num_vectors * VECTOR_CYCLES + RESET_CYCLES + 2) * CLK_PERIOD;
		#(timeout_ns);
		$display("timeout: the run did not finish within %0d ns", timeout_ns);
		$display("%0d vectors, %0d checks, %0d errors", num_vectors, checks, errors + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/x25519_field_vectors.mem
// columns: opcode (0 add, 1 sub, 2 add_red, 3 sub_red), a, b, expected result
// all values hex, elements are 264 bits, short values are zero extended
// add
0 0 0 0
0 1 2 3
0 ffffffffffffffffffffffffffffffff 1 100000000000000000000000000000000
0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 2 1
0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe
0 888888888888888888888888888888888888888888888888888888888888888888 888888888888888888888888888888888888888888888888888888888888888888 111111111111111111111111111111111111111111111111111111111111111110
0 8000000000000000000000000000000000000000000000000000000000000000 8000000000000000000000000000000000000000000000000000000000000000 10000000000000000000000000000000000000000000000000000000000000000
// sub
1 0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed
1 5 3 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffef
1 0 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
1 14 0 8000000000000000000000000000000000000000000000000000000000000001
1 100000000000000000000000000000000 1 80000000000000000000000000000000ffffffffffffffffffffffffffffffec
1 0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffee
1 0 10000000000000000000000000000000000000000000000000000000000000000 ff7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed
// add with weak reduction
2 1 2 3
2 8000000000000000000000000000000000000000000000000000000000000000 0 13
2 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0 25ff
2 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 13 13
2 888888888888888888888888888888888888888888888888888888888888888888 888888888888888888888888888888888888888888888888888888888888888888 1111111111111111111111111111111111111111111111111111111111111396
// sub with weak reduction
3 0 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed
3 14 0 14
3 0 10000000000000000000000000000000000000000000000000000000000000000 25da
3 0 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec
3 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 100000000000000000000000000000000 7ffffffffffffffffffffffffffffffeffffffffffffffffffffffffffffffec

// File: all.f
+incdir+hw
hw/x25519_field_pkg.sv
hw/x25519_ctrl_pkg.sv
hw/x25519_add.sv
hw/x25519_sub.sv
hw/x25519_reduce.sv
hw/x25519_pass_counter.sv
hw/x25519_op_sequencer.sv
hw/x25519_field_unit.sv
testbench/x25519_field_unit_tb.sv

// File: Bender.yml
package:
  name: x25519_field_unit

export_include_dirs:
  - hw

sources:
  # packages first, the datapath and the sequencer depend on them
  - include_dirs:
      - hw
    files:
      - hw/x25519_field_pkg.sv
      - hw/x25519_ctrl_pkg.sv
      - hw/x25519_add.sv
      - hw/x25519_sub.sv
      - hw/x25519_reduce.sv
      - hw/x25519_pass_counter.sv
      - hw/x25519_op_sequencer.sv
      - hw/x25519_field_unit.sv

  # testbench, reads testbench/x25519_field_vectors.mem at run time
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/x25519_field_unit_tb.sv
